// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Address map geometry
  localparam int unsigned ADDR_W = 15;
  localparam int unsigned ROW_W = 10;
  localparam int unsigned COL_W = 5;
  localparam int unsigned ROWS = 1024;
  localparam int unsigned ROW_BYTES = 32;
  localparam int unsigned ROW_BITS = ROW_BYTES * 8;
  localparam int unsigned BUS_BITS = ROW_BITS / 2;

  // Array latency and the timer that measures it
  localparam int unsigned ACCESS_CYCLES = 4;
  localparam int unsigned TIMER_W = 3;

  typedef logic [ADDR_W-1:0] mem_addr_t;
  typedef logic [ROW_W-1:0] row_addr_t;
  typedef logic [COL_W-1:0] col_addr_t;
  typedef logic [ROW_BITS-1:0] row_data_t;
  typedef logic [BUS_BITS-1:0] bus_data_t;
  typedef logic [ROW_BYTES-1:0] byte_mask_t;
  typedef logic [2:0] wsize_t;
  typedef logic [TIMER_W-1:0] timer_count_t;

  // Start value of the countdown to expiry at zero
  localparam timer_count_t TIMER_LOAD = timer_count_t'(ACCESS_CYCLES - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_finish
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/access_controller.sv
`default_nettype none

module access_controller (
  input  logic clk,
  input  logic rst_n,
  input  logic en,
  input  logic wr,
  input  logic expired,
  output logic start_count,
  output logic array_we,
  output logic array_re,
  output logic load_row,
  output logic latch_req,
  output logic busy,
  output logic done
);

  mem_pkg::ctrl_state_t state;
  mem_pkg::ctrl_state_t state_next;
  logic wr_q;
  logic issued;

  // Only an idle controller takes a request
  assign latch_req = en && (state == mem_pkg::st_idle);
  assign busy = (state != mem_pkg::st_idle);
  assign done = (state == mem_pkg::st_finish);

  // One array strobe per request when the timer runs out
  assign array_we = (state == mem_pkg::st_access) && expired && wr_q;
  assign array_re = (state == mem_pkg::st_access) && expired && !wr_q;
  assign load_row = array_re;

  always_comb
  begin
    state_next = state;
    case (state)
      mem_pkg::st_idle:
      begin
        if (latch_req)
          state_next = mem_pkg::st_access;
      end
      mem_pkg::st_access:
      begin
        // Wait one cycle after the strobe for the array row
        if (issued)
          state_next = mem_pkg::st_finish;
      end
      mem_pkg::st_finish:
      begin
        state_next = mem_pkg::st_idle;
      end
      default:
      begin
        state_next = mem_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state <= mem_pkg::st_idle;
      start_count <= 1'b0;
      issued <= 1'b0;
      wr_q <= 1'b0;
    end
    else
    begin
      state <= state_next;
      start_count <= latch_req;
      issued <= array_we || array_re;
      if (latch_req)
        wr_q <= wr;
    end
  end

endmodule

`default_nettype wire

// File: logic/access_timer.sv
`default_nettype none

module access_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic start_count,
  output logic expired
);

  mem_pkg::timer_count_t count;
  logic running;

  // High for the single cycle spent at zero
  assign expired = running && (count == '0);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count <= '0;
      running <= 1'b0;
    end
    else if (start_count)
    begin
      // A start always reloads even in the middle of a count
      count <= mem_pkg::TIMER_LOAD;
      running <= 1'b1;
    end
    else if (running)
    begin
      if (count == '0)
        running <= 1'b0;
      else
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/write_mask_gen.sv
`default_nettype none

module write_mask_gen (
  input  mem_pkg::col_addr_t  col,
  input  mem_pkg::wsize_t     write_size,
  output mem_pkg::byte_mask_t mask
);

  logic [3:0] run;

  // Sizes above 4 behave as 4
  always_comb
  begin
    case (write_size)
      3'd1: run = 4'b0001;
      3'd2: run = 4'b0011;
      3'd3: run = 4'b0111;
      default: run = 4'b1111;
    endcase
  end

  always_comb
  begin
    if (write_size == '0)
    begin
      // Whole half row picked by the top column bit
      if (col[4])
        mask = {16'hffff, 16'h0000};
      else
        mask = {16'h0000, 16'hffff};
    end
    else
    begin
      // Bytes shifted past bit 31 fall off here
      mask = mem_pkg::byte_mask_t'({28'b0, run}) << col;
    end
  end

endmodule

`default_nettype wire

// File: logic/row_buffer.sv
`default_nettype none

module row_buffer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                latch_req,
  input  logic                load_row,
  input  logic                wr,
  input  mem_pkg::mem_addr_t  addr,
  input  mem_pkg::wsize_t     write_size,
  input  mem_pkg::bus_data_t  bus_in,
  input  mem_pkg::row_data_t  rd_row,
  output mem_pkg::mem_addr_t  req_addr,
  output mem_pkg::wsize_t     req_size,
  output mem_pkg::row_data_t  wr_row,
  output mem_pkg::bus_data_t  bus_out
);

  mem_pkg::row_data_t shifted;
  logic req_wr;
  logic load_q;

  // Byte column times eight gives the bit offset
  assign shifted = mem_pkg::row_data_t'(bus_in) << {addr[4:0], 3'b000};

  // Request payload and the aligned row image
  always_ff @(posedge clk)
  begin
    if (latch_req)
    begin
      req_addr <= addr;
      req_size <= write_size;
      if (write_size == '0)
      begin
        if (addr[4])
          wr_row <= {bus_in, {mem_pkg::BUS_BITS{1'b0}}};
        else
          wr_row <= {{mem_pkg::BUS_BITS{1'b0}}, bus_in};
      end
      else
      begin
        wr_row <= shifted;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      req_wr <= 1'b0;
      load_q <= 1'b0;
      bus_out <= '0;
    end
    else
    begin
      if (latch_req)
        req_wr <= wr;
      // rd_row is valid one cycle after the read strobe
      load_q <= load_row;
      if (load_q && !req_wr)
      begin
        if (req_addr[4])
          bus_out <= rd_row[mem_pkg::ROW_BITS-1:mem_pkg::BUS_BITS];
        else
          bus_out <= rd_row[mem_pkg::BUS_BITS-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/sram_array.sv
`default_nettype none

module sram_array (
  input  logic                clk,
  input  logic                array_we,
  input  logic                array_re,
  input  mem_pkg::row_addr_t  row,
  input  mem_pkg::row_data_t  wr_row,
  input  mem_pkg::byte_mask_t mask,
  output mem_pkg::row_data_t  rd_row
);

  mem_pkg::row_data_t mem [mem_pkg::ROWS];

  // Byte lanes written only where the mask is set
  always_ff @(posedge clk)
  begin
    if (array_we)
    begin
      for (int b = 0; b < mem_pkg::ROW_BYTES; b++)
      begin
        if (mask[b])
          mem[row][b*8 +: 8] <= wr_row[b*8 +: 8];
      end
    end
  end

  // Registered row read that holds until the next read
  always_ff @(posedge clk)
  begin
    if (array_re)
      rd_row <= mem[row];
  end

endmodule

`default_nettype wire

// File: logic/main_memory.sv
`default_nettype none

module main_memory (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               en,
  input  logic               wr,
  input  mem_pkg::mem_addr_t addr,
  input  mem_pkg::wsize_t    write_size,
  input  mem_pkg::bus_data_t bus_in,
  output logic               busy,
  output logic               done,
  output mem_pkg::bus_data_t bus_out
);

  logic start_count;
  logic expired;
  logic array_we;
  logic array_re;
  logic load_row;
  logic latch_req;
  mem_pkg::mem_addr_t req_addr;
  mem_pkg::wsize_t req_size;
  mem_pkg::row_data_t wr_row;
  mem_pkg::row_data_t rd_row;
  mem_pkg::byte_mask_t mask;

  access_controller u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .wr          (wr),
    .expired     (expired),
    .start_count (start_count),
    .array_we    (array_we),
    .array_re    (array_re),
    .load_row    (load_row),
    .latch_req   (latch_req),
    .busy        (busy),
    .done        (done)
  );

  access_timer u_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_count (start_count),
    .expired     (expired)
  );

  // Mask and row index come from the latched request
  write_mask_gen u_mask (
    .col        (req_addr[4:0]),
    .write_size (req_size),
    .mask       (mask)
  );

  row_buffer u_buf (
    .clk        (clk),
    .rst_n      (rst_n),
    .latch_req  (latch_req),
    .load_row   (load_row),
    .wr         (wr),
    .addr       (addr),
    .write_size (write_size),
    .bus_in     (bus_in),
    .rd_row     (rd_row),
    .req_addr   (req_addr),
    .req_size   (req_size),
    .wr_row     (wr_row),
    .bus_out    (bus_out)
  );

  sram_array u_array (
    .clk      (clk),
    .array_we (array_we),
    .array_re (array_re),
    .row      (req_addr[14:5]),
    .wr_row   (wr_row),
    .mask     (mask),
    .rd_row   (rd_row)
  );

endmodule

`default_nettype wire

// File: tb/main_memory_properties.sv
`default_nettype none

module main_memory_properties (
  input logic clk,
  input logic rst_n,
  input logic latch_req,
  input logic busy,
  input logic done,
  input logic array_we,
  input logic array_re
);
  timeunit 1ns;
  timeprecision 1ps;

  done_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> !done
  ) else $error("done held high for more than one cycle");

  // Sampled values lag one edge, so done is seen on the seventh edge
  done_latency: assert property (
    @(posedge clk) disable iff (!rst_n) latch_req |-> ##7 done
  ) else $error("done did not follow acceptance after six cycles");

  done_not_early: assert property (
    @(posedge clk) disable iff (!rst_n) latch_req |-> ##6 !done
  ) else $error("done came one cycle early");

  strobes_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(array_we && array_re)
  ) else $error("array write and read strobes high together");

  idle_after_reset: assert property (
    @(posedge clk) !rst_n |=> !busy
  ) else $error("busy high after reset");

endmodule

bind main_memory main_memory_properties u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .latch_req (latch_req),
  .busy      (busy),
  .done      (done),
  .array_we  (array_we),
  .array_re  (array_re)
);

`default_nettype wire

// File: tb/tb_main_memory.sv
`default_nettype none

module tb_main_memory;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 50;
  localparam int LATENCY = int'(mem_pkg::ACCESS_CYCLES) + 2;

  logic clk;
  logic rst_n;
  logic en;
  logic wr;
  mem_pkg::mem_addr_t addr;
  mem_pkg::wsize_t write_size;
  mem_pkg::bus_data_t bus_in;
  logic busy;
  logic done;
  mem_pkg::bus_data_t bus_out;

  // Byte image of rows 0 to 15
  logic [7:0] model_mem [16][32];
  int checks;
  int errors;
  mem_pkg::mem_addr_t intr_addr;

  main_memory uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .wr         (wr),
    .addr       (addr),
    .write_size (write_size),
    .bus_in     (bus_in),
    .busy       (busy),
    .done       (done),
    .bus_out    (bus_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic mem_pkg::mem_addr_t make_addr(input int row, input int col);
    return mem_pkg::mem_addr_t'(row * 32 + col);
  endfunction

  function automatic mem_pkg::bus_data_t rand_bus();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  // Size 0 fills a half row and sizes 1 to 4 store low bytes up to byte 31
  function automatic void model_write(input mem_pkg::mem_addr_t a, input mem_pkg::wsize_t s,
                                      input mem_pkg::bus_data_t d);
    int row;
    int col;
    int n;
    row = int'(a[14:5]);
    col = int'(a[4:0]);
    if (s == 3'd0)
    begin
      for (int i = 0; i < 16; i++)
        model_mem[row][(a[4] ? 16 : 0) + i] = d[i*8 +: 8];
    end
    else
    begin
      n = (int'(s) > 4) ? 4 : int'(s);
      for (int i = 0; i < n; i++)
      begin
        if (col + i < 32)
          model_mem[row][col + i] = d[i*8 +: 8];
      end
    end
  endfunction

  function automatic mem_pkg::bus_data_t model_read(input mem_pkg::mem_addr_t a);
    mem_pkg::bus_data_t word;
    for (int i = 0; i < 16; i++)
      word[i*8 +: 8] = model_mem[int'(a[14:5])][(a[4] ? 16 : 0) + i];
    return word;
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // One request with an optional en pulse injected while busy
  task automatic run_request(input string name, input logic w, input mem_pkg::mem_addr_t a,
                             input mem_pkg::wsize_t s, input mem_pkg::bus_data_t d,
                             input int intrude);
    int edges;
    logic got;
    @(posedge clk);
    en <= 1'b1;
    wr <= w;
    addr <= a;
    write_size <= s;
    bus_in <= d;
    @(posedge clk);
    // Inputs only matter at the accepting edge
    en <= 1'b0;
    wr <= ~w;
    addr <= make_addr($urandom_range(15, 0), $urandom_range(31, 0));
    write_size <= mem_pkg::wsize_t'($urandom);
    bus_in <= rand_bus();
    edges = 0;
    got = 1'b0;
    while (!got && edges < TIMEOUT)
    begin
      @(negedge clk);
      // busy stays high from acceptance through the done cycle
      check_value({name, " busy"}, 128'(1), 128'(busy));
      if (done)
        got = 1'b1;
      else
      begin
        @(posedge clk);
        edges++;
        if (intrude != 0 && edges == intrude)
        begin
          intr_addr = make_addr($urandom_range(15, 0), $urandom_range(31, 0));
          en <= 1'b1;
          wr <= 1'b1;
          addr <= intr_addr;
          write_size <= mem_pkg::wsize_t'($urandom);
          bus_in <= rand_bus();
        end
        else if (intrude != 0 && edges == intrude + 1)
          en <= 1'b0;
      end
    end
    if (!got)
    begin
      errors++;
      $display("%s: done never came within %0d cycles", name, TIMEOUT);
    end
    else
    begin
      check_value({name, " latency"}, 128'(LATENCY), 128'(edges));
      if (w)
        model_write(a, s, d);
      else
        check_value({name, " data"}, model_read(a), bus_out);
    end
  endtask

  task automatic check_quiet(input string name);
    for (int n = 0; n < 8; n++)
    begin
      @(negedge clk);
      check_value({name, " extra done"}, 128'(0), 128'(done));
      check_value({name, " idle busy"}, 128'(0), 128'(busy));
    end
  endtask

  task automatic report_test(input int num, input string title, input int chk0,
                             input int err0);
    $display("test %0d %s: %0d checks, %0d errors", num, title, checks - chk0, errors - err0);
  endtask

  initial
  begin
    int row;
    int col;
    int chk0;
    int err0;
    logic w;
    void'($urandom(32'hec51));
    checks = 0;
    errors = 0;
    rst_n = 1'b0;
    en = 1'b0;
    wr = 1'b0;
    addr = '0;
    write_size = '0;
    bus_in = '0;
    intr_addr = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    chk0 = checks;
    err0 = errors;
    @(negedge clk);
    check_value("reset busy", 128'(0), 128'(busy));
    check_value("reset done", 128'(0), 128'(done));
    check_value("reset bus_out", '0, bus_out);
    report_test(1, "reset_state", chk0, err0);

    // Fill every row in use so later reads are defined
    chk0 = checks;
    err0 = errors;
    for (row = 0; row < 16; row++)
    begin
      run_request("fill lo", 1'b1, make_addr(row, $urandom_range(15, 0)), 3'd0, rand_bus(), 0);
      run_request("fill hi", 1'b1, make_addr(row, $urandom_range(31, 16)), 3'd0, rand_bus(), 0);
    end
    for (int i = 0; i < 12; i++)
    begin
      row = $urandom_range(15, 0);
      run_request("half read lo", 1'b0, make_addr(row, $urandom_range(15, 0)),
                  mem_pkg::wsize_t'($urandom), rand_bus(), 0);
      run_request("half read hi", 1'b0, make_addr(row, $urandom_range(31, 16)),
                  mem_pkg::wsize_t'($urandom), rand_bus(), 0);
    end
    report_test(2, "full_half_writes", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 48; i++)
    begin
      row = $urandom_range(15, 0);
      // Half of the writes land near the row end where bytes get clipped
      col = ($urandom_range(1, 0) == 1) ? int'($urandom_range(31, 29)) :
            int'($urandom_range(31, 0));
      run_request("partial write", 1'b1, make_addr(row, col),
                  mem_pkg::wsize_t'($urandom_range(4, 1)), rand_bus(), 0);
      run_request("partial read lo", 1'b0, make_addr(row, 0), 3'd0, rand_bus(), 0);
      run_request("partial read hi", 1'b0, make_addr(row, 16), 3'd0, rand_bus(), 0);
    end
    report_test(3, "partial_writes", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 24; i++)
    begin
      w = 1'(i % 2);
      run_request("busy en", w, make_addr($urandom_range(15, 0), $urandom_range(31, 0)),
                  mem_pkg::wsize_t'($urandom), rand_bus(), $urandom_range(4, 1));
      check_quiet("busy en");
      run_request("busy en readback", 1'b0, intr_addr, 3'd0, rand_bus(), 0);
    end
    report_test(4, "latency_and_busy_en", chk0, err0);

    chk0 = checks;
    err0 = errors;
    for (int i = 0; i < 400; i++)
    begin
      run_request("random mix", 1'($urandom),
                  make_addr($urandom_range(15, 0), $urandom_range(31, 0)),
                  mem_pkg::wsize_t'($urandom), rand_bus(), 0);
    end
    report_test(5, "random_mix", chk0, err0);

    $display("5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
logic/mem_pkg.sv
logic/access_controller.sv
logic/access_timer.sv
logic/write_mask_gen.sv
logic/row_buffer.sv
logic/sram_array.sv
logic/main_memory.sv
tb/main_memory_properties.sv
tb/tb_main_memory.sv

// File: Makefile
TOP := tb_main_memory

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f src.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
